/* common/fpu_cfg_pkg.sv */
`default_nettype none

package fpu_cfg_pkg;

  // ----------------------------------------
  // datapath widths
  // ----------------------------------------
  localparam int FLEN = 64;                 // width of one fp register

  typedef logic [FLEN-1:0] flen_t;          // register-wide operand or result
  typedef logic [31:0]     sword_t;         // single precision value

  // ----------------------------------------
  // commit tag carried through the pipe
  // ----------------------------------------
  localparam int CMT_ID_W = 6;
  localparam int GRP_W    = 4;
  localparam int RNID_W   = 7;

  typedef logic [CMT_ID_W-1:0] cmt_id_t;    // commit id
  typedef logic [GRP_W-1:0]    grp_id_t;    // dispatch group mask
  typedef logic [RNID_W-1:0]   rnid_t;      // rename register id

  typedef enum logic {
    GPR = 1'b0,
    FPR = 1'b1
  } reg_type_e;

  localparam sword_t CANON_NAN_S = 32'h7fc0_0000;
  localparam flen_t  CANON_NAN_D = 64'h7ff8_0000_0000_0000;

  localparam int PIPE_LAT = 3;              // decode, execute, writeback

endpackage

`default_nettype wire

/* common/fpu_op_pkg.sv */
`default_nettype none

package fpu_op_pkg;

  // ----------------------------------------
  // operation codes, codes 9..15 are illegal
  // ----------------------------------------
  typedef enum logic [3:0] {
    OP_FSGNJ  = 4'd0,
    OP_FSGNJN = 4'd1,
    OP_FSGNJX = 4'd2,
    OP_FMIN   = 4'd3,
    OP_FMAX   = 4'd4,
    OP_FEQ    = 4'd5,
    OP_FLT    = 4'd6,
    OP_FLE    = 4'd7,
    OP_FCLASS = 4'd8
  } fpu_op_e;

  typedef enum logic {
    FMT_S = 1'b0,                           // fp32, nan-boxed in a 64-bit register
    FMT_D = 1'b1
  } fmt_e;

  // NV DZ OF UF NX, msb first
  typedef logic [4:0] fflags_t;

  localparam int FFLAG_NV = 4;

  // ----------------------------------------
  // fclass one-hot mask
  // ----------------------------------------
  typedef logic [9:0] classmask_t;

  localparam int CLS_NEG_INF  = 0;
  localparam int CLS_NEG_NORM = 1;
  localparam int CLS_NEG_SUB  = 2;
  localparam int CLS_NEG_ZERO = 3;
  localparam int CLS_POS_ZERO = 4;
  localparam int CLS_POS_SUB  = 5;
  localparam int CLS_POS_NORM = 6;
  localparam int CLS_POS_INF  = 7;
  localparam int CLS_SNAN     = 8;
  localparam int CLS_QNAN     = 9;

endpackage

`default_nettype wire

/* noncomp/fpu_classify.sv */
`default_nettype none

module fpu_classify (
  input  fpu_cfg_pkg::flen_t      i_operand,
  input  fpu_op_pkg::fmt_e        i_fmt,
  output fpu_op_pkg::classmask_t  o_class,
  output logic                    o_is_nan,
  output logic                    o_is_snan,
  output logic                    o_is_zero
);
  import fpu_op_pkg::*;

  logic w_sign;
  logic w_exp_ones;
  logic w_exp_zero;
  logic w_man_zero;
  logic w_quiet;           // msb of the mantissa
  logic w_is_inf;
  logic w_is_sub;
  logic w_is_norm;

  // field extraction for the selected format
  always_comb begin
    if (i_fmt == FMT_D) begin
      w_sign     = i_operand[63];
      w_exp_ones = &i_operand[62:52];
      w_exp_zero = ~|i_operand[62:52];
      w_man_zero = ~|i_operand[51:0];
      w_quiet    = i_operand[51];
    end else begin
      w_sign     = i_operand[31];
      w_exp_ones = &i_operand[30:23];
      w_exp_zero = ~|i_operand[30:23];
      w_man_zero = ~|i_operand[22:0];
      w_quiet    = i_operand[22];
    end
  end

  assign w_is_inf  = w_exp_ones & w_man_zero;
  assign o_is_nan  = w_exp_ones & ~w_man_zero;
  assign o_is_snan = o_is_nan & ~w_quiet;
  assign o_is_zero = w_exp_zero & w_man_zero;
  assign w_is_sub  = w_exp_zero & ~w_man_zero;
  assign w_is_norm = ~w_exp_ones & ~w_exp_zero;

  always_comb begin
    o_class               = '0;
    o_class[CLS_NEG_INF]  = w_is_inf & w_sign;
    o_class[CLS_NEG_NORM] = w_is_norm & w_sign;
    o_class[CLS_NEG_SUB]  = w_is_sub & w_sign;
    o_class[CLS_NEG_ZERO] = o_is_zero & w_sign;
    o_class[CLS_POS_ZERO] = o_is_zero & ~w_sign;
    o_class[CLS_POS_SUB]  = w_is_sub & ~w_sign;
    o_class[CLS_POS_NORM] = w_is_norm & ~w_sign;
    o_class[CLS_POS_INF]  = w_is_inf & ~w_sign;
    o_class[CLS_SNAN]     = o_is_snan;               // sign ignored for nans
    o_class[CLS_QNAN]     = o_is_nan & w_quiet;
  end

endmodule

`default_nettype wire

/* noncomp/fpu_noncomp_exec.sv */
`default_nettype none

module fpu_noncomp_exec (
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic                   i_valid,
  input  fpu_op_pkg::fpu_op_e    i_op,
  input  fpu_op_pkg::fmt_e       i_fmt,
  input  fpu_cfg_pkg::flen_t     i_rs1,
  input  fpu_cfg_pkg::flen_t     i_rs2,
  input  fpu_cfg_pkg::cmt_id_t   i_cmt_id,
  input  fpu_cfg_pkg::grp_id_t   i_grp_id,
  input  fpu_cfg_pkg::rnid_t     i_rnid,
  input  fpu_cfg_pkg::reg_type_e i_reg_type,
  output logic                   o_valid,
  output fpu_op_pkg::fpu_op_e    o_op,
  output fpu_op_pkg::fmt_e       o_fmt,
  output fpu_cfg_pkg::flen_t     o_result,
  output fpu_op_pkg::fflags_t    o_fflags,
  output fpu_cfg_pkg::cmt_id_t   o_cmt_id,
  output fpu_cfg_pkg::grp_id_t   o_grp_id,
  output fpu_cfg_pkg::rnid_t     o_rnid,
  output fpu_cfg_pkg::reg_type_e o_reg_type
);
  import fpu_cfg_pkg::*;
  import fpu_op_pkg::*;

  classmask_t  w_class_a;
  logic        w_nan_a, w_snan_a, w_zero_a;
  logic        w_nan_b, w_snan_b, w_zero_b;
  logic        w_sgn_a, w_sgn_b;
  logic [62:0] w_mag_a, w_mag_b;
  logic        w_any_nan, w_any_snan;
  logic        w_eq;
  logic        w_lt_total;    // -0 below +0, used by min/max
  logic        w_lt;          // ieee lt, zeros compare equal
  flen_t       w_canon;
  flen_t       w_result;
  fflags_t     w_fflags;

  fpu_classify cls_a (
    .i_operand (i_rs1),
    .i_fmt     (i_fmt),
    .o_class   (w_class_a),
    .o_is_nan  (w_nan_a),
    .o_is_snan (w_snan_a),
    .o_is_zero (w_zero_a)
  );

  fpu_classify cls_b (
    .i_operand (i_rs2),
    .i_fmt     (i_fmt),
    .o_class   (),
    .o_is_nan  (w_nan_b),
    .o_is_snan (w_snan_b),
    .o_is_zero (w_zero_b)
  );

  // ----------------------------------------
  // sign / magnitude split
  // ----------------------------------------
  assign w_sgn_a = (i_fmt == FMT_D) ? i_rs1[63] : i_rs1[31];
  assign w_sgn_b = (i_fmt == FMT_D) ? i_rs2[63] : i_rs2[31];
  assign w_mag_a = (i_fmt == FMT_D) ? i_rs1[62:0] : {32'h0, i_rs1[30:0]};
  assign w_mag_b = (i_fmt == FMT_D) ? i_rs2[62:0] : {32'h0, i_rs2[30:0]};
  assign w_canon = (i_fmt == FMT_D) ? CANON_NAN_D : {{(FLEN-32){1'b0}}, CANON_NAN_S};

  assign w_any_nan  = w_nan_a | w_nan_b;
  assign w_any_snan = w_snan_a | w_snan_b;

  // upper word is zero for fp32, so a full compare works for both formats
  assign w_eq = (i_rs1 == i_rs2) | (w_zero_a & w_zero_b);

  assign w_lt_total = (w_sgn_a != w_sgn_b) ? w_sgn_a :
                      w_sgn_a              ? (w_mag_a > w_mag_b) :
                                             (w_mag_a < w_mag_b);
  assign w_lt = w_lt_total & ~(w_zero_a & w_zero_b);

  always_comb begin
    w_result = '0;
    w_fflags = '0;
    case (i_op)
      OP_FSGNJ, OP_FSGNJN, OP_FSGNJX : begin
        w_result = i_rs1;
        if (i_fmt == FMT_D) begin
          w_result[63] = (i_op == OP_FSGNJ)  ? w_sgn_b :
                         (i_op == OP_FSGNJN) ? ~w_sgn_b : (w_sgn_a ^ w_sgn_b);
        end else begin
          w_result[31] = (i_op == OP_FSGNJ)  ? w_sgn_b :
                         (i_op == OP_FSGNJN) ? ~w_sgn_b : (w_sgn_a ^ w_sgn_b);
        end
      end
      OP_FMIN, OP_FMAX : begin
        if (w_nan_a & w_nan_b) begin
          w_result = w_canon;
        end else if (w_nan_a) begin
          w_result = i_rs2;                          // the other operand wins
        end else if (w_nan_b) begin
          w_result = i_rs1;
        end else if (i_op == OP_FMIN) begin
          w_result = w_lt_total ? i_rs1 : i_rs2;
        end else begin
          w_result = w_lt_total ? i_rs2 : i_rs1;
        end
        w_fflags[FFLAG_NV] = w_any_snan;
      end
      OP_FEQ : begin
        w_result[0]        = w_eq & ~w_any_nan;
        w_fflags[FFLAG_NV] = w_any_snan;             // quiet compare
      end
      OP_FLT : begin
        w_result[0]        = w_lt & ~w_any_nan;
        w_fflags[FFLAG_NV] = w_any_nan;              // signaling compare
      end
      OP_FLE : begin
        w_result[0]        = (w_lt | w_eq) & ~w_any_nan;
        w_fflags[FFLAG_NV] = w_any_nan;
      end
      OP_FCLASS : begin
        w_result[CLS_QNAN:0] = w_class_a;
      end
      default : begin
        w_result = '0;
      end
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid) begin
      o_op       <= i_op;
      o_fmt      <= i_fmt;
      o_result   <= w_result;
      o_fflags   <= w_fflags;
      o_cmt_id   <= i_cmt_id;
      o_grp_id   <= i_grp_id;
      o_rnid     <= i_rnid;
      o_reg_type <= i_reg_type;
    end
  end

endmodule

`default_nettype wire

/* hw/fpu_decode_stage.sv */
`default_nettype none

module fpu_decode_stage (
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic                   i_valid,
  input  fpu_op_pkg::fpu_op_e    i_op,
  input  fpu_op_pkg::fmt_e       i_fmt,
  input  fpu_cfg_pkg::flen_t     i_rs1,
  input  fpu_cfg_pkg::flen_t     i_rs2,
  input  fpu_cfg_pkg::cmt_id_t   i_cmt_id,
  input  fpu_cfg_pkg::grp_id_t   i_grp_id,
  input  fpu_cfg_pkg::rnid_t     i_rnid,
  input  fpu_cfg_pkg::reg_type_e i_reg_type,
  output logic                   o_valid,
  output fpu_op_pkg::fpu_op_e    o_op,
  output fpu_op_pkg::fmt_e       o_fmt,
  output fpu_cfg_pkg::flen_t     o_rs1,
  output fpu_cfg_pkg::flen_t     o_rs2,
  output fpu_cfg_pkg::cmt_id_t   o_cmt_id,
  output fpu_cfg_pkg::grp_id_t   o_grp_id,
  output fpu_cfg_pkg::rnid_t     o_rnid,
  output fpu_cfg_pkg::reg_type_e o_reg_type
);
  import fpu_cfg_pkg::*;
  import fpu_op_pkg::*;

  logic  w_legal;
  logic  w_issue;
  flen_t w_rs1;
  flen_t w_rs2;

  // fp32 operand must be nan-boxed, otherwise it reads as the canonical nan.
  // upper word is cleared so later stages only look at the low word
  function automatic flen_t unbox(input flen_t rs, input fmt_e fmt);
    flen_t res;
    if (fmt == FMT_D) begin
      res = rs;
    end else if (&rs[FLEN-1:32]) begin
      res = {{(FLEN-32){1'b0}}, rs[31:0]};
    end else begin
      res = {{(FLEN-32){1'b0}}, CANON_NAN_S};
    end
    return res;
  endfunction

  always_comb begin
    case (i_op)
      OP_FSGNJ, OP_FSGNJN, OP_FSGNJX,
      OP_FMIN, OP_FMAX,
      OP_FEQ, OP_FLT, OP_FLE,
      OP_FCLASS : w_legal = 1'b1;
      default   : w_legal = 1'b0;                  // dropped silently
    endcase
  end

  assign w_issue = i_valid & w_legal;
  assign w_rs1   = unbox(i_rs1, i_fmt);
  assign w_rs2   = unbox(i_rs2, i_fmt);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= w_issue;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_issue) begin
      o_op       <= i_op;
      o_fmt      <= i_fmt;
      o_rs1      <= w_rs1;
      o_rs2      <= w_rs2;
      o_cmt_id   <= i_cmt_id;
      o_grp_id   <= i_grp_id;
      o_rnid     <= i_rnid;
      o_reg_type <= i_reg_type;
    end
  end

endmodule

`default_nettype wire

/* hw/fpu_writeback_stage.sv */
`default_nettype none

module fpu_writeback_stage (
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic                   i_valid,
  input  fpu_op_pkg::fpu_op_e    i_op,
  input  fpu_op_pkg::fmt_e       i_fmt,
  input  fpu_cfg_pkg::flen_t     i_result,
  input  fpu_op_pkg::fflags_t    i_fflags,
  input  fpu_cfg_pkg::cmt_id_t   i_cmt_id,
  input  fpu_cfg_pkg::grp_id_t   i_grp_id,
  input  fpu_cfg_pkg::rnid_t     i_rnid,
  input  fpu_cfg_pkg::reg_type_e i_reg_type,
  output logic                   o_valid,
  output fpu_cfg_pkg::flen_t     o_result,
  output fpu_op_pkg::fflags_t    o_fflags,
  output fpu_cfg_pkg::cmt_id_t   o_cmt_id,
  output fpu_cfg_pkg::grp_id_t   o_grp_id,
  output fpu_cfg_pkg::rnid_t     o_rnid,
  output fpu_cfg_pkg::reg_type_e o_reg_type
);
  import fpu_cfg_pkg::*;
  import fpu_op_pkg::*;

  flen_t w_result;

  always_comb begin
    case (i_op)
      OP_FSGNJ, OP_FSGNJN, OP_FSGNJX, OP_FMIN, OP_FMAX : begin
        w_result = (i_fmt == FMT_D) ? i_result :
                   {{(FLEN-32){1'b1}}, i_result[31:0]};   // nan-box fp32
      end
      default : begin
        // compare and fclass go to the integer file
        w_result = {{(FLEN-CLS_QNAN-1){1'b0}}, i_result[CLS_QNAN:0]};
      end
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_valid    <= 1'b0;
      o_result   <= '0;
      o_fflags   <= '0;
      o_cmt_id   <= '0;
      o_grp_id   <= '0;
      o_rnid     <= '0;
      o_reg_type <= GPR;
    end else begin
      o_valid <= i_valid;
      if (i_valid) begin                                 // data hold otherwise
        o_result   <= w_result;
        o_fflags   <= i_fflags;
        o_cmt_id   <= i_cmt_id;
        o_grp_id   <= i_grp_id;
        o_rnid     <= i_rnid;
        o_reg_type <= i_reg_type;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/fpu_noncomp_top.sv */
`default_nettype none

// three stages with one register each, so a legal op leaves
// fpu_cfg_pkg::PIPE_LAT cycles after it was sampled
module fpu_noncomp_top (
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  logic                  i_valid,
  input  fpu_op_pkg::fpu_op_e   i_op,
  input  fpu_op_pkg::fmt_e      i_fmt,
  input  fpu_cfg_pkg::flen_t    i_rs1,
  input  fpu_cfg_pkg::flen_t    i_rs2,
  input  fpu_cfg_pkg::cmt_id_t  i_cmt_id,
  input  fpu_cfg_pkg::grp_id_t  i_grp_id,
  input  fpu_cfg_pkg::rnid_t    i_rnid,
  input  fpu_cfg_pkg::reg_type_e i_reg_type,
  output logic                  o_valid,
  output fpu_cfg_pkg::flen_t    o_result,
  output fpu_op_pkg::fflags_t   o_fflags,
  output fpu_cfg_pkg::cmt_id_t  o_cmt_id,
  output fpu_cfg_pkg::grp_id_t  o_grp_id,
  output fpu_cfg_pkg::rnid_t    o_rnid,
  output fpu_cfg_pkg::reg_type_e o_reg_type
);
  import fpu_cfg_pkg::*;
  import fpu_op_pkg::*;

  // ----------------------------------------
  // decode -> execute
  // ----------------------------------------
  logic      d_valid;
  fpu_op_e   d_op;
  fmt_e      d_fmt;
  flen_t     d_rs1;
  flen_t     d_rs2;
  cmt_id_t   d_cmt_id;
  grp_id_t   d_grp_id;
  rnid_t     d_rnid;
  reg_type_e d_reg_type;

  // ----------------------------------------
  // execute -> writeback
  // ----------------------------------------
  logic      e_valid;
  fpu_op_e   e_op;
  fmt_e      e_fmt;
  flen_t     e_result;
  fflags_t   e_fflags;
  cmt_id_t   e_cmt_id;
  grp_id_t   e_grp_id;
  rnid_t     e_rnid;
  reg_type_e e_reg_type;

  fpu_decode_stage u_decode (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_valid    (i_valid),
    .i_op       (i_op),
    .i_fmt      (i_fmt),
    .i_rs1      (i_rs1),
    .i_rs2      (i_rs2),
    .i_cmt_id   (i_cmt_id),
    .i_grp_id   (i_grp_id),
    .i_rnid     (i_rnid),
    .i_reg_type (i_reg_type),
    .o_valid    (d_valid),
    .o_op       (d_op),
    .o_fmt      (d_fmt),
    .o_rs1      (d_rs1),
    .o_rs2      (d_rs2),
    .o_cmt_id   (d_cmt_id),
    .o_grp_id   (d_grp_id),
    .o_rnid     (d_rnid),
    .o_reg_type (d_reg_type)
  );

  fpu_noncomp_exec u_exec (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_valid    (d_valid),
    .i_op       (d_op),
    .i_fmt      (d_fmt),
    .i_rs1      (d_rs1),
    .i_rs2      (d_rs2),
    .i_cmt_id   (d_cmt_id),
    .i_grp_id   (d_grp_id),
    .i_rnid     (d_rnid),
    .i_reg_type (d_reg_type),
    .o_valid    (e_valid),
    .o_op       (e_op),
    .o_fmt      (e_fmt),
    .o_result   (e_result),
    .o_fflags   (e_fflags),
    .o_cmt_id   (e_cmt_id),
    .o_grp_id   (e_grp_id),
    .o_rnid     (e_rnid),
    .o_reg_type (e_reg_type)
  );

  fpu_writeback_stage u_writeback (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_valid    (e_valid),
    .i_op       (e_op),
    .i_fmt      (e_fmt),
    .i_result   (e_result),
    .i_fflags   (e_fflags),
    .i_cmt_id   (e_cmt_id),
    .i_grp_id   (e_grp_id),
    .i_rnid     (e_rnid),
    .i_reg_type (e_reg_type),
    .o_valid    (o_valid),
    .o_result   (o_result),
    .o_fflags   (o_fflags),
    .o_cmt_id   (o_cmt_id),
    .o_grp_id   (o_grp_id),
    .o_rnid     (o_rnid),
    .o_reg_type (o_reg_type)
  );

endmodule

`default_nettype wire

/* tests/fpu_noncomp_properties.sv */
`default_nettype none

module fpu_noncomp_properties (
  input  logic                i_clk,
  input  logic                i_rst_n,
  input  logic                i_valid,
  input  fpu_op_pkg::fpu_op_e i_op,
  input  logic                i_out_valid
);
  timeunit 1ns;
  timeprecision 1ps;

  import fpu_cfg_pkg::*;
  import fpu_op_pkg::*;

  logic w_legal;

  assign w_legal = i_op inside {OP_FSGNJ, OP_FSGNJN, OP_FSGNJX, OP_FMIN, OP_FMAX,
                                OP_FEQ, OP_FLT, OP_FLE, OP_FCLASS};

  // ----------------------------------------
  // reset and latency
  // ----------------------------------------
  a_quiet_in_reset : assert property (@(posedge i_clk) !i_rst_n |-> !i_out_valid)
    else $error("o_valid high while reset is asserted");

  a_fixed_latency : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_valid && w_legal) |-> ##PIPE_LAT i_out_valid)
    else $error("legal operation did not leave after the pipeline latency");

endmodule

`default_nettype wire

/* tests/tb_fpu_noncomp.sv */
`default_nettype none

module tb_fpu_noncomp;
  timeunit 1ns;
  timeprecision 1ps;

  import fpu_cfg_pkg::*;
  import fpu_op_pkg::*;

  localparam int N_OPS      = 2000;
  localparam int CLK_PERIOD = 10;

  typedef struct packed {
    flen_t       result;
    fflags_t     fflags;
    cmt_id_t     cmt_id;
    grp_id_t     grp_id;
    rnid_t       rnid;
    reg_type_e   reg_type;
    logic [31:0] cycle;          // cycle in which o_valid must be seen
  } expect_t;

  logic      i_clk = 1'b0;
  logic      i_rst_n;
  logic      i_valid;
  fpu_op_e   i_op;
  fmt_e      i_fmt;
  flen_t     i_rs1;
  flen_t     i_rs2;
  cmt_id_t   i_cmt_id;
  grp_id_t   i_grp_id;
  rnid_t     i_rnid;
  reg_type_e i_reg_type;
  logic      o_valid;
  flen_t     o_result;
  fflags_t   o_fflags;
  cmt_id_t   o_cmt_id;
  grp_id_t   o_grp_id;
  rnid_t     o_rnid;
  reg_type_e o_reg_type;

  expect_t exp_q[$];
  int      cycle_cnt = 0;
  logic    seen_out  = 1'b0;

  fpu_noncomp_top dut0 (.*);

  bind fpu_noncomp_top fpu_noncomp_properties props0 (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_valid     (i_valid),
    .i_op        (i_op),
    .i_out_valid (o_valid)
  );

  // ----------------------------------------
  // reporting
  // ----------------------------------------
  task automatic stop_run(input string why);
    $display("%s (at %0t ns)", why, $time);
    $display("FAIL: see errors above");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      $display("FAIL: see errors above");
      $fatal(1, "value mismatch");
    end
  endtask

  // ----------------------------------------
  // reference model
  // ----------------------------------------
  function automatic flen_t unbox_ref(input flen_t v, input fmt_e fmt);
    if (fmt == FMT_D) return v;
    if (v[63:32] != 32'hffff_ffff) return {32'h0, CANON_NAN_S};  // not boxed
    return {32'h0, v[31:0]};
  endfunction

  function automatic int class_of(input flen_t v, input fmt_e fmt);
    logic        s;
    logic [10:0] ex;
    logic [51:0] man;
    logic        top_exp;
    if (fmt == FMT_D) begin
      s       = v[63];
      ex      = v[62:52];
      man     = v[51:0];
      top_exp = (ex == 11'h7ff);
    end else begin
      s       = v[31];
      ex      = {3'b0, v[30:23]};
      man     = {29'b0, v[22:0]};
      top_exp = (ex == 11'h0ff);
    end
    if (top_exp && man != 0) return ((fmt == FMT_D) ? man[51] : man[22]) ? CLS_QNAN : CLS_SNAN;
    if (top_exp) return s ? CLS_NEG_INF : CLS_POS_INF;
    if (ex == 0 && man == 0) return s ? CLS_NEG_ZERO : CLS_POS_ZERO;
    if (ex == 0) return s ? CLS_NEG_SUB : CLS_POS_SUB;
    return s ? CLS_NEG_NORM : CLS_POS_NORM;
  endfunction

  // negative values shifted by one so -0 sorts below +0
  function automatic logic signed [65:0] order_key(input flen_t v, input fmt_e fmt);
    logic signed [65:0] mag;
    logic               s;
    s   = (fmt == FMT_D) ? v[63] : v[31];
    mag = (fmt == FMT_D) ? {3'b0, v[62:0]} : {35'b0, v[30:0]};
    return s ? (-mag - 66'sd1) : mag;
  endfunction

  function automatic expect_t model(input fpu_op_e op, input fmt_e fmt,
                                    input flen_t rs1, input flen_t rs2);
    expect_t e;
    flen_t   a;
    flen_t   b;
    flen_t   r;
    int      ca;
    int      cb;
    logic    nan_a;
    logic    nan_b;
    logic    snan_any;
    logic    zeros;
    logic    lt;
    logic    eq;
    logic    sa;
    logic    sb;
    logic    sr;
    e        = '0;
    r        = '0;
    a        = unbox_ref(rs1, fmt);
    b        = unbox_ref(rs2, fmt);
    ca       = class_of(a, fmt);
    cb       = class_of(b, fmt);
    nan_a    = (ca == CLS_SNAN) || (ca == CLS_QNAN);
    nan_b    = (cb == CLS_SNAN) || (cb == CLS_QNAN);
    snan_any = (ca == CLS_SNAN) || (cb == CLS_SNAN);
    zeros    = (ca inside {CLS_NEG_ZERO, CLS_POS_ZERO}) &&
               (cb inside {CLS_NEG_ZERO, CLS_POS_ZERO});
    lt       = order_key(a, fmt) < order_key(b, fmt);
    eq       = (a == b) || zeros;
    sa       = (fmt == FMT_D) ? a[63] : a[31];
    sb       = (fmt == FMT_D) ? b[63] : b[31];
    case (op)
      OP_FSGNJ, OP_FSGNJN, OP_FSGNJX : begin
        sr = (op == OP_FSGNJ) ? sb : (op == OP_FSGNJN) ? !sb : (sa ^ sb);
        r  = a;
        if (fmt == FMT_D) r[63] = sr;
        else r[31] = sr;
      end
      OP_FMIN, OP_FMAX : begin
        if (nan_a && nan_b) r = (fmt == FMT_D) ? CANON_NAN_D : {32'h0, CANON_NAN_S};
        else if (nan_a) r = b;
        else if (nan_b) r = a;
        else if (op == OP_FMIN) r = lt ? a : b;
        else r = lt ? b : a;
        e.fflags[FFLAG_NV] = snan_any;
      end
      OP_FEQ : begin
        r[0]               = eq && !(nan_a || nan_b);
        e.fflags[FFLAG_NV] = snan_any;
      end
      OP_FLT : begin
        r[0]               = lt && !zeros && !(nan_a || nan_b);
        e.fflags[FFLAG_NV] = nan_a || nan_b;
      end
      OP_FLE : begin
        r[0]               = (lt || eq) && !(nan_a || nan_b);
        e.fflags[FFLAG_NV] = nan_a || nan_b;
      end
      OP_FCLASS : r[ca] = 1'b1;
      default   : r = '0;
    endcase
    if (fmt == FMT_S && op inside {OP_FSGNJ, OP_FSGNJN, OP_FSGNJX, OP_FMIN, OP_FMAX})
      r[63:32] = 32'hffff_ffff;                      // boxed fp32 result
    e.result = r;
    return e;
  endfunction

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  function automatic flen_t pick_operand(input fmt_e fmt, input flen_t other);
    logic        s;
    logic [10:0] ex;
    logic [51:0] man;
    flen_t       v;
    int unsigned kind;
    s    = 1'($urandom());
    man  = {20'($urandom()), $urandom()};
    ex   = 11'($urandom_range(1, (fmt == FMT_D) ? 2046 : 254));
    kind = $urandom_range(0, 9);
    case (kind)
      0 : begin                                                   // signed zero
        ex  = '0;
        man = '0;
      end
      1 : begin                                                   // infinity
        ex  = '1;
        man = '0;
      end
      2 : begin                                                   // quiet nan
        ex      = '1;
        man[51] = 1'b1;
        man[22] = 1'b1;
      end
      3 : begin                                                   // signaling nan
        ex      = '1;
        man[51] = 1'b0;
        man[22] = 1'b0;
        man[0]  = 1'b1;
      end
      4 : begin                                                   // subnormal
        ex     = '0;
        man[0] = 1'b1;
      end
      default : begin
      end
    endcase
    if (fmt == FMT_D) v = {s, ex, man};
    else v = {32'hffff_ffff, s, ex[7:0], man[22:0]};
    if (kind == 5) v = other;                                     // equal operands
    if (kind == 6 && fmt == FMT_S) v[63:32] = $urandom() & 32'hfffe_ffff;  // unboxed
    return v;
  endfunction

  task automatic drive_cycle();
    int unsigned pick;
    expect_t     e;
    pick       = $urandom_range(0, 19);
    i_op       = (pick < 18) ? fpu_op_e'(pick % 9) : fpu_op_e'(9 + $urandom_range(0, 6));
    i_valid    = ($urandom_range(0, 9) < 7);
    i_fmt      = fmt_e'($urandom_range(0, 1));
    i_rs1      = pick_operand(i_fmt, i_rs2);
    i_rs2      = pick_operand(i_fmt, i_rs1);
    i_cmt_id   = cmt_id_t'($urandom());
    i_grp_id   = grp_id_t'($urandom());
    i_rnid     = rnid_t'($urandom());
    i_reg_type = reg_type_e'($urandom_range(0, 1));
    if (i_valid && pick < 18) begin
      e          = model(i_op, i_fmt, i_rs1, i_rs2);
      e.cmt_id   = i_cmt_id;
      e.grp_id   = i_grp_id;
      e.rnid     = i_rnid;
      e.reg_type = i_reg_type;
      e.cycle    = cycle_cnt + PIPE_LAT;
      exp_q.push_back(e);
    end
  endtask

  initial begin
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  always @(posedge i_clk) cycle_cnt <= cycle_cnt + 1;

  initial begin
    void'($urandom(3));
    i_rst_n    = 1'b0;
    i_valid    = 1'b0;
    i_op       = OP_FSGNJ;
    i_fmt      = FMT_S;
    i_rs1      = '0;
    i_rs2      = '0;
    i_cmt_id   = '0;
    i_grp_id   = '0;
    i_rnid     = '0;
    i_reg_type = GPR;
    repeat (5) @(posedge i_clk);
    #1 i_rst_n = 1'b1;
    for (int i = 0; i < N_OPS; i++) begin
      @(posedge i_clk);
      #1;
      drive_cycle();
    end
    @(posedge i_clk);
    #1 i_valid = 1'b0;
    repeat (PIPE_LAT + 2) @(posedge i_clk);                       // drain and look for extras
    if (exp_q.size() != 0) begin
      stop_run($sformatf("%0d expected results never came out", exp_q.size()));
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

  // ----------------------------------------
  // scoreboard samples at the falling edge
  // ----------------------------------------
  always @(negedge i_clk) begin : scoreboard
    expect_t e;
    if (!i_rst_n) check_value("o_valid", o_valid, 0);
    if (!seen_out && !o_valid) begin                              // untouched after reset
      check_value("o_result", o_result, 0);
      check_value("o_fflags", o_fflags, 0);
      check_value("o_cmt_id", o_cmt_id, 0);
      check_value("o_grp_id", o_grp_id, 0);
      check_value("o_rnid", o_rnid, 0);
      check_value("o_reg_type", o_reg_type, 0);
    end
    if (o_valid) begin
      seen_out = 1'b1;
      if (exp_q.size() == 0) begin
        stop_run("o_valid went high with no operation in flight");
      end else begin
        e = exp_q.pop_front();
        check_value("latency cycle", cycle_cnt, e.cycle);
        check_value("o_result", o_result, e.result);
        check_value("o_fflags", o_fflags, e.fflags);
        check_value("o_cmt_id", o_cmt_id, e.cmt_id);
        check_value("o_grp_id", o_grp_id, e.grp_id);
        check_value("o_rnid", o_rnid, e.rnid);
        check_value("o_reg_type", o_reg_type, e.reg_type);
      end
    end
  end

  initial begin
    #((N_OPS + PIPE_LAT + 20) * CLK_PERIOD);
    stop_run("watchdog expired before the run finished");
  end

endmodule

`default_nettype wire

/* list.f */
common/fpu_cfg_pkg.sv
common/fpu_op_pkg.sv
noncomp/fpu_classify.sv
noncomp/fpu_noncomp_exec.sv
hw/fpu_decode_stage.sv
hw/fpu_writeback_stage.sv
hw/fpu_noncomp_top.sv
tests/fpu_noncomp_properties.sv
tests/tb_fpu_noncomp.sv
